// File: filelist.f
+incdir+src
src/hub75_pkg.sv
src/timeout.sv
src/frame_buffer.sv
src/pixel_slicer.sv
src/matrix_scan.sv
src/hub75_top.sv
testbench/hub75_tb.sv

// File: src/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// pixel pair memory
// host writes one side and the scan reads the other
module frame_buffer import hub75_pkg::*; (
    input  wire logic        clk_in,
    input  wire logic        wr_en,
    input  wire fb_addr_t    wr_addr,
    input  wire pixel_pair_t wr_data,
    input  wire fb_addr_t    rd_addr,  // {row, column} from the scan
    output pixel_pair_t      rd_data   // valid one rising edge after rd_addr
);

    localparam int DEPTH = 2 ** $bits(fb_addr_t); // 1024 pairs

    pixel_pair_t mem [0:DEPTH-1];

    // host port, a write lands at the edge where wr_en is seen
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read so it maps onto block RAM
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: src/hub75_params.svh
`ifndef HUB75_PARAMS_SVH
`define HUB75_PARAMS_SVH

// panel geometry for a 64x32 panel driven at 1/16 scan
`define HUB75_COLS 64      // pixels shifted per line
`define HUB75_SCAN_ROWS 16 // row addresses, each one lights an upper and a lower line

// colour depth, one bit plane per bit of each channel
`define HUB75_DEPTH 6

// output enable width of the least significant plane in clk_in cycles
// every higher plane doubles it
`define HUB75_OE_BASE 23

// the next line may start shifting once the enable counter is at or below this
// must cover the 64 load cycles plus the latch delay
`define HUB75_OVERLAP 67

`endif

// File: src/hub75_pkg.sv
`default_nettype none
`include "hub75_params.svh"

package hub75_pkg;

    typedef logic [$clog2(`HUB75_COLS)-1:0] col_t;      // column address
    typedef logic [$clog2(`HUB75_SCAN_ROWS)-1:0] row_t; // row address on the panel
    typedef logic [`HUB75_DEPTH-1:0] chan_t;            // one colour channel intensity
    typedef logic [`HUB75_DEPTH-1:0] mask_t;            // one-hot bit plane select
    typedef logic [9:0] oe_count_t;                     // holds up to 23 << 5
    typedef logic [$bits(row_t)+$bits(col_t)-1:0] fb_addr_t; // {row, column}

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pixel_t;

    // both pixels shifted out together on one line
    typedef struct packed {
        pixel_t upper; // row r
        pixel_t lower; // row r + 16
    } pixel_pair_t;

    typedef struct packed {
        logic r1;
        logic g1;
        logic b1;
        logic r2;
        logic g2;
        logic b2;
    } panel_data_t;

endpackage

`default_nettype wire

// File: src/hub75_top.sv
`timescale 1ns/1ps
`default_nettype none

// HUB75 panel driver, frame buffer feeding scan and slicer
module hub75_top import hub75_pkg::*; (
    input  wire logic        clk_in,
    input  wire logic        reset,
    input  wire logic        wr_en,      // host write strobe, always accepted
    input  wire fb_addr_t    wr_addr,
    input  wire pixel_pair_t wr_data,
    output panel_data_t      panel_data,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             output_enable,
    output row_t             row_address_active
);

    col_t column_address;
    row_t row_address;
    mask_t brightness_mask;
    fb_addr_t rd_addr;
    pixel_pair_t rd_data;

    assign rd_addr = {row_address, column_address}; // row above column

    frame_buffer u_frame_buffer (
        .clk_in (clk_in),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    matrix_scan u_matrix_scan (
        .clk_in            (clk_in),
        .reset             (reset),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .brightness_mask   (brightness_mask),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable)
    );

    pixel_slicer u_pixel_slicer (
        .clk_in         (clk_in),
        .reset          (reset),
        .pixels         (rd_data),
        .brightness_mask(brightness_mask),
        .panel_data     (panel_data)
    );

endmodule

`default_nettype wire

// File: src/matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none
`include "hub75_params.svh"

// scan sequencer for line shift, latch and binary coded output enable
module matrix_scan import hub75_pkg::*; (
    input  wire logic clk_in,
    input  wire logic reset,
    output col_t      column_address,     // column being read for the shift
    output row_t      row_address,        // row being shifted now
    output row_t      row_address_active, // row lit by output_enable
    output mask_t     brightness_mask,    // plane being shifted now
    output logic      clk_pixel,          // gated shift clock
    output logic      row_latch,
    output logic      output_enable       // active high
);

    localparam int LOAD_WIDTH = $clog2(`HUB75_COLS) + 1; // wide enough to hold 64
    localparam mask_t MASK_MSB = mask_t'(1) << (`HUB75_DEPTH - 1);

    logic [1:0] state;        // state_advance history, older bit on the left
    logic state_advance;
    logic line_start;
    logic line_busy;          // a shift or its latch is still in flight

    logic clk_pixel_load_en;  // load window, 64 cycles
    logic pixel_en_d;         // first half of the two cycle delay
    logic clk_pixel_en;       // gates clk_pixel
    logic [1:0] row_latch_state;
    logic latch_next;

    mask_t brightness_mask_active;  // plane lit by output_enable
    oe_count_t brightness_timeout;  // enable width for the active plane
    oe_count_t brightness_counter;  // remaining enable cycles

    assign clk_pixel = clk_in & clk_pixel_en;
    assign row_latch = (row_latch_state == 2'b10); // falling edge of the pixel enable
    assign latch_next = row_latch_state[0] & ~clk_pixel_en;

    // 64 load cycles per line
    timeout #(
        .COUNTER_WIDTH(LOAD_WIDTH)
    ) timeout_load (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (LOAD_WIDTH'(`HUB75_COLS)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // column address counts 63 down to 0 and holds there
    timeout #(
        .COUNTER_WIDTH($bits(col_t))
    ) timeout_column (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (col_t'(`HUB75_COLS - 1)),
        .counter(column_address),
        .running()
    );

    // pixel enable trails the load window by two cycles
    // one for the frame buffer read and one for the slicer register
    always_ff @(negedge clk_in) begin
        if (reset) begin
            pixel_en_d <= 1'b0;
            clk_pixel_en <= 1'b0;
            row_latch_state <= 2'b00;
            brightness_mask <= MASK_MSB;
            brightness_mask_active <= '0;
            row_address <= '0;
            row_address_active <= '0;
        end else begin
            pixel_en_d <= clk_pixel_load_en;
            clk_pixel_en <= pixel_en_d;
            row_latch_state <= {row_latch_state[0], clk_pixel_en};
            if (latch_next) begin
                brightness_mask_active <= brightness_mask; // hand the shifted line to the LEDs
                row_address_active <= row_address;
                if (brightness_mask[0]) begin
                    brightness_mask <= MASK_MSB; // last plane done so move to the next row
                    row_address <= row_address + 1'b1; // wraps at 16
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    // binary coded modulation, each plane lights twice as long as the one below
    always_comb begin
        case (brightness_mask_active)
            6'b000001: brightness_timeout = oe_count_t'(`HUB75_OE_BASE);
            6'b000010: brightness_timeout = oe_count_t'(`HUB75_OE_BASE) << 1;
            6'b000100: brightness_timeout = oe_count_t'(`HUB75_OE_BASE) << 2;
            6'b001000: brightness_timeout = oe_count_t'(`HUB75_OE_BASE) << 3;
            6'b010000: brightness_timeout = oe_count_t'(`HUB75_OE_BASE) << 4;
            6'b100000: brightness_timeout = oe_count_t'(`HUB75_OE_BASE) << 5;
            default:   brightness_timeout = oe_count_t'(1); // no plane latched yet
        endcase
    end

    // enable window opens on the rising edge after the latch
    timeout #(
        .COUNTER_WIDTH($bits(oe_count_t))
    ) timeout_output_enable (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (row_latch),
        .value  (brightness_timeout),
        .counter(brightness_counter),
        .running(output_enable)
    );

    assign line_busy = clk_pixel_load_en | pixel_en_d | clk_pixel_en | (|row_latch_state);

    // shift the next line while the current plane is still lit
    // it finishes just as the enable window closes
    assign state_advance = !line_busy &&
        (!output_enable || (brightness_counter <= oe_count_t'(`HUB75_OVERLAP)));
    assign line_start = (state == 2'b01); // rising edge of state_advance

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00; // first edge comes right after reset
        end else begin
            state <= {state[0], state_advance};
        end
    end

    // exactly one plane is ever selected for the shift
    assert property (@(negedge clk_in) disable iff (reset) $onehot(brightness_mask));

    // the latch must never land inside an enable window
    assert property (@(posedge clk_in) disable iff (reset) !(row_latch && output_enable));

endmodule

`default_nettype wire

// File: src/pixel_slicer.sv
`timescale 1ns/1ps
`default_nettype none

// one bit plane of both pixels of a pair, registered on the falling edge
module pixel_slicer import hub75_pkg::*; (
    input  wire logic        clk_in,
    input  wire logic        reset,
    input  wire pixel_pair_t pixels,          // from the frame buffer read port
    input  wire mask_t       brightness_mask, // plane being shifted
    output panel_data_t      panel_data       // stable at the next rising edge
);

    panel_data_t plane_bits;

    // mask picks the same bit from all six channels
    always_comb begin
        plane_bits.r1 = |(pixels.upper.r & brightness_mask);
        plane_bits.g1 = |(pixels.upper.g & brightness_mask);
        plane_bits.b1 = |(pixels.upper.b & brightness_mask);
        plane_bits.r2 = |(pixels.lower.r & brightness_mask); // lower half of the panel
        plane_bits.g2 = |(pixels.lower.g & brightness_mask);
        plane_bits.b2 = |(pixels.lower.b & brightness_mask);
    end

    // half a cycle of setup before the gated pixel clock rises
    always_ff @(negedge clk_in) begin
        if (reset) begin
            panel_data <= '0;
        end else begin
            panel_data <= plane_bits;
        end
    end

    // the scan must hand over a single plane or the bits would merge
    assert property (@(negedge clk_in) disable iff (reset) $onehot(brightness_mask));

endmodule

`default_nettype wire

// File: src/timeout.sv
`timescale 1ns/1ps
`default_nettype none

// countdown timer, loads on start and runs down to zero
module timeout #(
    parameter int COUNTER_WIDTH = 8
) (
    input  wire logic                     clk_in,
    input  wire logic                     reset,
    input  wire logic                     start,   // ignored while running
    input  wire logic [COUNTER_WIDTH-1:0] value,
    output logic      [COUNTER_WIDTH-1:0] counter,
    output logic                          running
);

    logic [COUNTER_WIDTH-1:0] last_value; // value of the most recent load
    logic load;

    assign running = (counter != '0);
    assign load = start && !running; // only an idle timer takes a new value

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (load) begin
            counter <= value;
        end else if (running) begin
            counter <= counter - 1'b1; // stops at zero
        end
    end

    always_ff @(posedge clk_in) begin
        if (load) begin
            last_value <= value;
        end
    end

    // a running count only ever falls from the value it was loaded with
    assert property (@(posedge clk_in) disable iff (reset)
        running |-> (counter <= last_value));

endmodule

`default_nettype wire

// File: testbench/hub75_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "hub75_params.svh"

// random frame buffer fill and a panel model that follows two whole frames
module hub75_tb
    import hub75_pkg::*;
();

    localparam int FB_WORDS = 1 << $bits(fb_addr_t);                    // 1024 pairs
    localparam int FRAME_LATCHES = `HUB75_SCAN_ROWS * `HUB75_DEPTH;    // 96 lines per frame
    localparam int CHECK_LATCHES = 2 * FRAME_LATCHES;                  // two checked frames
    // rough frame length from the enable widths plus the two short planes that wait on the shift
    localparam int FRAME_EST = `HUB75_SCAN_ROWS *
        (`HUB75_OE_BASE * ((1 << `HUB75_DEPTH) - 1) + 2 * (`HUB75_COLS + 6));
    // fill plus up to a frame waiting for row 0 plus the checked frames
    localparam int MAX_CYCLES = FB_WORDS + 3 * FRAME_EST + 2000;

    logic clk_in;
    logic reset;
    logic wr_en;
    fb_addr_t wr_addr;
    pixel_pair_t wr_data;
    panel_data_t panel_data;
    logic clk_pixel;
    logic row_latch;
    logic output_enable;
    row_t row_address_active;

    pixel_pair_t shadow [0:FB_WORDS-1]; // what the frame buffer should hold
    logic [31:0] rng = 32'h8610_ec6b;
    int errors = 0;
    int cycles = 0;
    int check_from = -1;     // first checked latch or -1 until the fill is done
    int latch_count = 0;     // latches seen since reset
    int last_latch = -1;     // latch that owns the current enable window
    int edge_total = 0;      // clk_pixel edges since reset
    int edge_base = 0;       // edge_total at the last latch
    int oe_run = 0;          // enable cycles seen in the current window
    int latches_checked = 0;
    int edges_checked = 0;
    logic prev_latch = 1'b0;

    hub75_top UUT (
        .clk_in            (clk_in),
        .reset             (reset),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .panel_data        (panel_data),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .row_address_active(row_address_active)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // latch n belongs to the checked frames
    function automatic bit in_window(input int n);
        return (check_from >= 0) && (n >= check_from) && (n < check_from + CHECK_LATCHES);
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in; // 20 ns period
    end

    // stop a run that never reaches the end of the checked frames
    always @(posedge clk_in) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the checked frames did not finish within %0d cycles, errors: %0d",
                     cycles, errors);
            $display("test failed");
            $finish;
        end
    end

    // stimulus fills the frame buffer then waits for the model to cover two frames
    initial begin
        pixel_pair_t data;
        logic [31:0] rnd_hi;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;
        for (int i = 0; i < FB_WORDS; i++) begin // one word per cycle from reset release
            rng = xorshift32(rng);
            rnd_hi = rng;
            rng = xorshift32(rng);
            data = {rnd_hi[3:0], rng};
            wr_en <= 1'b1;
            wr_addr <= fb_addr_t'(i);
            wr_data <= data;
            shadow[i] = data;
            @(posedge clk_in);
        end
        wr_en <= 1'b0;
        // next row 0 plane 5 line whose shift starts after the fill
        check_from = ((latch_count / FRAME_LATCHES) + 1) * FRAME_LATCHES;
        wait (latch_count > check_from + CHECK_LATCHES);
        @(posedge clk_in);
        compare("pixel_edges_checked", CHECK_LATCHES * `HUB75_COLS, edges_checked);
        $display("errors: %0d, latches checked: %0d, pixel edges checked: %0d",
                 errors, latches_checked, edges_checked);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // panel shift register model sampling data at each rising pixel clock
    always @(posedge clk_pixel) begin : pixel_edge
        int k;
        int n;
        int plane;
        pixel_pair_t pair;
        panel_data_t expected;
        if (!reset) begin
            k = edge_total - edge_base;  // k-th edge of this line
            n = latch_count;             // line ends at latch n
            if (in_window(n) && k < `HUB75_COLS) begin
                plane = `HUB75_DEPTH - 1 - (n % `HUB75_DEPTH);
                pair = shadow[{row_t'((n / `HUB75_DEPTH) % `HUB75_SCAN_ROWS),
                               col_t'(`HUB75_COLS - 1 - k)}]; // columns go out 63 first
                expected.r1 = pair.upper.r[plane];
                expected.g1 = pair.upper.g[plane];
                expected.b1 = pair.upper.b[plane];
                expected.r2 = pair.lower.r[plane];
                expected.g2 = pair.lower.g[plane];
                expected.b2 = pair.lower.b[plane];
                compare($sformatf("panel_data latch %0d edge %0d", n, k), expected, panel_data);
                edges_checked++;
            end
            edge_total++;
        end
    end

    // latch and enable are sampled just before each rising edge where both are stable
    always begin : sample
        @(negedge clk_in);
        #5;
        if (!reset) begin
            compare("latch_oe_overlap", 0, row_latch && output_enable);
            compare("latch_pulse_width", 0, row_latch && prev_latch);
            if (output_enable) begin
                oe_run++;
            end else if (oe_run != 0) begin
                if (in_window(last_latch)) begin
                    compare($sformatf("oe_width latch %0d", last_latch),
                            `HUB75_OE_BASE << (`HUB75_DEPTH - 1 - (last_latch % `HUB75_DEPTH)),
                            oe_run);
                end
                oe_run = 0;
            end
            if (row_latch && !prev_latch) begin
                if (in_window(latch_count)) begin
                    compare($sformatf("pixel_edges latch %0d", latch_count), `HUB75_COLS,
                            edge_total - edge_base);
                    compare($sformatf("row_address_active latch %0d", latch_count),
                            (latch_count / `HUB75_DEPTH) % `HUB75_SCAN_ROWS, row_address_active);
                    latches_checked++;
                end
                last_latch = latch_count;
                latch_count++;
                edge_base = edge_total; // next line starts counting here
            end
            prev_latch = row_latch;
        end
    end

endmodule

`default_nettype wire
